/* bus_strobe.sv */
// bus_strobe: one-cycle read and write strobes from the z80 iorq/rd/wr levels
`timescale 1ns/100ps

module bus_strobe (
	input  logic zclk,
	input  logic rst,
	input  logic iorq,
	input  logic rd,
	input  logic wr,
	output logic port_rd,
	output logic port_wr
);

	logic rd_lvl;
	logic wr_lvl;
	logic rd_prev;
	logic wr_prev;

	assign rd_lvl = iorq & rd;
	assign wr_lvl = iorq & wr;

	// strobe on the first high sample after a low one
	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			rd_prev <= 1'b0;
			wr_prev <= 1'b0;
			port_rd <= 1'b0;
			port_wr <= 1'b0;
		end
		else
		begin
			rd_prev <= rd_lvl;
			wr_prev <= wr_lvl;
			port_rd <= rd_lvl & ~rd_prev;
			port_wr <= wr_lvl & ~wr_prev;
		end
	end

endmodule

/* comport_bridge.sv */
// comport_bridge: four-phase req/ack link to the external uart, stalls the cpu meanwhile
`timescale 1ns/100ps

module comport_bridge (
	input  logic                   zclk,
	input  logic                   rst,
	input  logic                   port_rd,
	input  logic                   port_wr,
	input  logic                   hit_com,
	input  zports_pkg::port_addr_u addr,
	input  logic [7:0]             din,
	input  logic                   com_ack,
	input  logic [7:0]             com_rdata,
	output logic                   com_req,
	output logic                   com_rnw,
	output logic [2:0]             com_unit,
	output logic [7:0]             com_wdata,
	output logic [7:0]             com_rdata_latched,
	output logic                   io_wait
);

	logic [1:0] state;
	logic       start;

	assign start = (port_rd | port_wr) & hit_com;

	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			state   <= zports_pkg::BR_IDLE;
			com_req <= 1'b0;
			io_wait <= 1'b0;
		end
		else
		begin
			case (state)
				zports_pkg::BR_IDLE:
				begin
					if (start)
					begin
						com_req <= 1'b1;
						io_wait <= 1'b1;
						state   <= zports_pkg::BR_REQ;
					end
				end
				zports_pkg::BR_REQ:
				begin
					if (com_ack)
					begin
						com_req <= 1'b0;
						state   <= zports_pkg::BR_REL;
					end
				end
				zports_pkg::BR_REL:
				begin
					if (!com_ack) // responder finished
					begin
						io_wait <= 1'b0;
						state   <= zports_pkg::BR_DONE;
					end
				end
				default:
					state <= zports_pkg::BR_IDLE;
			endcase
		end
	end

	// request payload, only loaded while req and ack are both low
	always_ff @(posedge zclk)
	begin
		if (state == zports_pkg::BR_IDLE && start)
		begin
			com_unit  <= addr.fields.unit;
			com_rnw   <= port_rd;
			com_wdata <= din;
		end
	end

	always_ff @(posedge zclk)
	begin
		if (state == zports_pkg::BR_REQ && com_ack && com_rnw)
			com_rdata_latched <= com_rdata; // valid while ack is high
	end

endmodule

/* port_decode.sv */
// port_decode: internal port hit flags and read data multiplexer
`timescale 1ns/100ps

module port_decode (
	input  zports_pkg::port_addr_u addr,
	input  logic                   rd,
	input  logic                   iorq,
	input  logic                   dos,
	input  logic [4:0]             keys_in,
	input  logic                   tape_read,
	input  logic [4:0]             kj_in,
	input  logic [7:0]             sd_dataout,
	input  logic [7:0]             rampage0,
	input  logic [7:0]             rampage1,
	input  logic [7:0]             rampage2,
	input  logic [7:0]             rampage3,
	input  logic [7:0]             sysconf,
	input  logic [7:0]             memconf,
	input  logic [7:0]             im2vect,
	input  logic                   status_pwrup,
	input  logic [7:0]             com_rdata_latched,
	output logic                   hit_fe,
	output logic                   hit_xt,
	output logic                   hit_7ffd,
	output logic                   hit_sdcfg,
	output logic                   hit_sddat,
	output logic                   hit_com,
	output logic                   porthit,
	output logic                   dataout,
	output logic [7:0]             dout
);

	logic       hit_kjoy;
	logic [7:0] status_byte;
	logic [7:0] xt_rdata;

	assign hit_fe    = (addr.bytes.lo == zports_pkg::PORT_FE);
	assign hit_xt    = (addr.bytes.lo == zports_pkg::PORT_XT);
	assign hit_7ffd  = (addr.bytes.lo == zports_pkg::PORT_FD) & ~addr.fields.sel_hi;
	assign hit_kjoy  = (addr.bytes.lo == zports_pkg::PORT_KJOY) & ~dos; // 1F is fdc in dos
	assign hit_sdcfg = (addr.bytes.lo == zports_pkg::PORT_SDCFG) & ~dos;
	assign hit_sddat = (addr.bytes.lo == zports_pkg::PORT_SDDAT) & ~dos;
	assign hit_com   = (addr.bytes.lo == zports_pkg::PORT_COM);

	assign porthit = hit_fe | hit_xt | hit_7ffd | hit_kjoy | hit_sdcfg | hit_sddat | hit_com;
	assign dataout = porthit & iorq & rd;

	// extended register read-back
	always_comb
	begin
		status_byte = 8'h00;
		status_byte[zports_pkg::PWRUP_BIT] = status_pwrup;

		case (addr.bytes.hi)
			zports_pkg::XT_STATUS:          xt_rdata = status_byte;
			zports_pkg::XT_RAMPAGE:         xt_rdata = rampage0;
			zports_pkg::XT_RAMPAGE + 8'd1:  xt_rdata = rampage1;
			zports_pkg::XT_RAMPAGE + 8'd2:  xt_rdata = rampage2;
			zports_pkg::XT_RAMPAGE + 8'd3:  xt_rdata = rampage3;
			zports_pkg::XT_SYSCONF:         xt_rdata = sysconf;
			zports_pkg::XT_MEMCONF:         xt_rdata = memconf;
			zports_pkg::XT_IM2VECT:         xt_rdata = im2vect;
			default:                        xt_rdata = 8'hFF;
		endcase
	end

	// hits are exclusive, so the order here does not matter
	always_comb
	begin
		if (hit_fe)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (hit_xt)
			dout = xt_rdata;
		else if (hit_kjoy)
			dout = {3'b000, kj_in};
		else if (hit_sdcfg)
			dout = 8'h00; // card present, not write protected
		else if (hit_sddat)
			dout = sd_dataout;
		else if (hit_com)
			dout = com_rdata_latched;
		else
			dout = 8'hFF; // floating bus
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module zports_tb \
	-f zports.f -o zports_sim || exit 1
result="$(./obj_dir/zports_sim)"
echo "$result"
echo "$result" | grep -q "SIMULATION PASSED" && exit 0 || exit 1

/* xt_config_regs.sv */
// xt_config_regs: #nnAF config registers, #7FFD paging, sd chip select and power-up flag
`timescale 1ns/100ps

module xt_config_regs (
	input  logic                   zclk,
	input  logic                   rst,
	input  logic                   port_rd,
	input  logic                   port_wr,
	input  logic                   hit_xt,
	input  logic                   hit_7ffd,
	input  logic                   hit_sdcfg,
	input  logic                   hit_sddat,
	input  zports_pkg::port_addr_u addr,
	input  logic [7:0]             din,
	input  logic                   wr,
	output logic [7:0]             rampage0,
	output logic [7:0]             rampage1,
	output logic [7:0]             rampage2,
	output logic [7:0]             rampage3,
	output logic [7:0]             sysconf,
	output logic [7:0]             memconf,
	output logic [7:0]             im2vect,
	output logic [31:0]            xt_page,
	output logic                   status_pwrup,
	output logic                   sdcs_n,
	output logic                   sd_start,
	output logic [7:0]             sd_datain
);

	logic [3:0][7:0] rampage;
	logic [7:0]      p7ffd;
	logic            pwrup_flag;
	logic            lock128;
	logic            xt_wr;
	logic            p7ffd_wr;
	logic            status_rd;

	assign xt_wr     = port_wr & hit_xt;
	assign p7ffd_wr  = port_wr & hit_7ffd & ~p7ffd[zports_pkg::LOCK_BIT];
	assign status_rd = port_rd & hit_xt & (addr.bytes.hi == zports_pkg::XT_STATUS);
	assign lock128   = (memconf[7:6] == 2'b01); // 128k lock mode

	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			rampage <= zports_pkg::RAMPAGE_RST;
			sysconf <= zports_pkg::SYSCONF_RST;
			memconf <= zports_pkg::MEMCONF_RST;
			im2vect <= zports_pkg::IM2VECT_RST;
			p7ffd   <= 8'h00;
		end
		else if (p7ffd_wr)
		begin
			p7ffd      <= din;
			memconf[0] <= din[4]; // rom select
			rampage[3] <= {3'b000, lock128 ? 2'b00 : din[7:6], din[2:0]};
		end
		else if (xt_wr)
		begin
			if (addr.bytes.hi[7:2] == zports_pkg::XT_RAMPAGE[7:2])
				rampage[addr.bytes.hi[1:0]] <= din;
			if (addr.bytes.hi == zports_pkg::XT_SYSCONF)
				sysconf <= din;
			if (addr.bytes.hi == zports_pkg::XT_MEMCONF)
				memconf <= din;
			if (addr.bytes.hi == zports_pkg::XT_IM2VECT)
				im2vect <= din;
		end
	end

	// set by reset, cleared by the first status read
	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			pwrup_flag   <= 1'b1;
			status_pwrup <= 1'b0;
		end
		else if (status_rd)
		begin
			status_pwrup <= pwrup_flag;
			pwrup_flag   <= 1'b0;
		end
	end

	always_ff @(posedge zclk)
	begin
		if (rst)
			sdcs_n <= 1'b1; // card deselected
		else if (port_wr & hit_sdcfg)
			sdcs_n <= din[1];
	end

	// spi byte transfer on every data port access
	assign sd_start  = (port_rd | port_wr) & hit_sddat;
	assign sd_datain = wr ? din : 8'hFF;

	assign rampage0 = rampage[0];
	assign rampage1 = rampage[1];
	assign rampage2 = rampage[2];
	assign rampage3 = rampage[3];
	assign xt_page  = rampage;

endmodule

/* zports.f */
zports_pkg.sv
bus_strobe.sv
port_decode.sv
xt_config_regs.sv
comport_bridge.sv
zports.sv
zports_assert.sv
zports_tb.sv

/* zports.sv */
// zports: z80 i/o port block with config registers, sd control and uart bridge
`timescale 1ns/100ps

module zports (
	input  logic        zclk,
	input  logic        rst,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	input  logic        iorq,
	input  logic        rd,
	input  logic        wr,
	input  logic        dos,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [4:0]  kj_in,
	output logic [31:0] xt_page,
	output logic [7:0]  sysconf,
	output logic [7:0]  memconf,
	output logic [7:0]  im2vect,
	output logic        sdcs_n,
	output logic        sd_start,
	output logic [7:0]  sd_datain,
	input  logic [7:0]  sd_dataout,
	output logic        com_req,
	input  logic        com_ack,
	output logic        com_rnw,
	output logic [2:0]  com_unit,
	output logic [7:0]  com_wdata,
	input  logic [7:0]  com_rdata,
	output logic        io_wait
);

	logic       port_rd;
	logic       port_wr;
	logic       hit_xt;
	logic       hit_7ffd;
	logic       hit_sdcfg;
	logic       hit_sddat;
	logic       hit_com;
	logic [7:0] rampage0;
	logic [7:0] rampage1;
	logic [7:0] rampage2;
	logic [7:0] rampage3;
	logic       status_pwrup;
	logic [7:0] com_rdata_latched;

	bus_strobe u_strobe (
		.zclk    (zclk),
		.rst     (rst),
		.iorq    (iorq),
		.rd      (rd),
		.wr      (wr),
		.port_rd (port_rd),
		.port_wr (port_wr)
	);

	// hit_fe only feeds porthit and the read mux inside the decoder
	port_decode u_decode (
		.addr              (a),
		.rd                (rd),
		.iorq              (iorq),
		.dos               (dos),
		.keys_in           (keys_in),
		.tape_read         (tape_read),
		.kj_in             (kj_in),
		.sd_dataout        (sd_dataout),
		.rampage0          (rampage0),
		.rampage1          (rampage1),
		.rampage2          (rampage2),
		.rampage3          (rampage3),
		.sysconf           (sysconf),
		.memconf           (memconf),
		.im2vect           (im2vect),
		.status_pwrup      (status_pwrup),
		.com_rdata_latched (com_rdata_latched),
		.hit_fe            (),
		.hit_xt            (hit_xt),
		.hit_7ffd          (hit_7ffd),
		.hit_sdcfg         (hit_sdcfg),
		.hit_sddat         (hit_sddat),
		.hit_com           (hit_com),
		.porthit           (porthit),
		.dataout           (dataout),
		.dout              (dout)
	);

	xt_config_regs u_regs (
		.zclk         (zclk),
		.rst          (rst),
		.port_rd      (port_rd),
		.port_wr      (port_wr),
		.hit_xt       (hit_xt),
		.hit_7ffd     (hit_7ffd),
		.hit_sdcfg    (hit_sdcfg),
		.hit_sddat    (hit_sddat),
		.addr         (a),
		.din          (din),
		.wr           (wr),
		.rampage0     (rampage0),
		.rampage1     (rampage1),
		.rampage2     (rampage2),
		.rampage3     (rampage3),
		.sysconf      (sysconf),
		.memconf      (memconf),
		.im2vect      (im2vect),
		.xt_page      (xt_page),
		.status_pwrup (status_pwrup),
		.sdcs_n       (sdcs_n),
		.sd_start     (sd_start),
		.sd_datain    (sd_datain)
	);

	comport_bridge u_bridge (
		.zclk              (zclk),
		.rst               (rst),
		.port_rd           (port_rd),
		.port_wr           (port_wr),
		.hit_com           (hit_com),
		.addr              (a),
		.din               (din),
		.com_ack           (com_ack),
		.com_rdata         (com_rdata),
		.com_req           (com_req),
		.com_rnw           (com_rnw),
		.com_unit          (com_unit),
		.com_wdata         (com_wdata),
		.com_rdata_latched (com_rdata_latched),
		.io_wait           (io_wait)
	);

endmodule

/* zports_assert.sv */
// zports_assert: uart handshake and port strobe protocol checks, bound into zports
`timescale 1ns/100ps

module zports_assert (
	input logic       zclk,
	input logic       rst,
	input logic       port_rd,
	input logic       port_wr,
	input logic       com_req,
	input logic       com_ack,
	input logic [2:0] com_unit,
	input logic [7:0] com_wdata
);

	int fail_cnt = 0;

	req_quiet_on_ack: assert property (@(posedge zclk) disable iff (rst)
		com_ack |=> !$rose(com_req))
	else
	begin
		fail_cnt++;
		$error("com_req rose while com_ack was high");
	end

	req_held: assert property (@(posedge zclk) disable iff (rst)
		com_req && !com_ack |=> com_req) // no early release
	else
	begin
		fail_cnt++;
		$error("com_req dropped before com_ack");
	end

	payload_stable: assert property (@(posedge zclk) disable iff (rst)
		com_req |=> $stable(com_unit) && $stable(com_wdata))
	else
	begin
		fail_cnt++;
		$error("com_unit or com_wdata changed during a request");
	end

	// one strobe per access, no read or write strobe right after another
	strobe_single: assert property (@(posedge zclk) disable iff (rst)
		(port_rd | port_wr) |=> !(port_rd | port_wr))
	else
	begin
		fail_cnt++;
		$error("port strobes high in two consecutive cycles");
	end

endmodule

bind zports zports_assert u_assert (
	.zclk      (zclk),
	.rst       (rst),
	.port_rd   (port_rd),
	.port_wr   (port_wr),
	.com_req   (com_req),
	.com_ack   (com_ack),
	.com_unit  (com_unit),
	.com_wdata (com_wdata)
);

/* zports_pkg.sv */
// zports shared definitions: port numbers, xt register indices, reset values, address view
package zports_pkg;

	// low address byte of the internal ports
	localparam logic [7:0] PORT_FE    = 8'hFE; // keyboard, tape in
	localparam logic [7:0] PORT_FD    = 8'hFD; // 128k paging, #7FFD
	localparam logic [7:0] PORT_XT    = 8'hAF; // extended config, #nnAF
	localparam logic [7:0] PORT_KJOY  = 8'h1F; // kempston joystick
	localparam logic [7:0] PORT_SDCFG = 8'h77;
	localparam logic [7:0] PORT_SDDAT = 8'h57;
	localparam logic [7:0] PORT_COM   = 8'hEF; // #F8EF..#FFEF uart

	// register index in the high byte of #nnAF
	localparam logic [7:0] XT_STATUS  = 8'h00;
	localparam logic [7:0] XT_RAMPAGE = 8'h10; // #10..#13
	localparam logic [7:0] XT_SYSCONF = 8'h20;
	localparam logic [7:0] XT_MEMCONF = 8'h21;
	localparam logic [7:0] XT_IM2VECT = 8'h25;

	// values after reset
	localparam logic [7:0] SYSCONF_RST = 8'h01; // 7 MHz turbo
	localparam logic [7:0] MEMCONF_RST = 8'h04; // rom map off
	localparam logic [7:0] IM2VECT_RST = 8'hFF;

	// page 0 at index 0, page 3 at index 3
	localparam logic [3:0][7:0] RAMPAGE_RST = {
		8'h00,
		8'h02,
		8'h05,
		8'h00
	};

	localparam int LOCK_BIT  = 5; // #7FFD self-lock
	localparam int PWRUP_BIT = 5; // power-up flag in status byte

	// uart bridge fsm
	localparam logic [1:0] BR_IDLE = 2'd0;
	localparam logic [1:0] BR_REQ  = 2'd1; // req high, waiting for ack
	localparam logic [1:0] BR_REL  = 2'd2; // req dropped, waiting for ack low
	localparam logic [1:0] BR_DONE = 2'd3;

	// the port address is seen either as two bytes or, for the uart
	// unit and the a15 select, as bit fields
	typedef union packed {
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
		struct packed {
			logic       sel_hi; // a15
			logic [3:0] spare;  // a14..a11
			logic [2:0] unit;   // a10..a8, uart channel
			logic [7:0] lo;
		} fields;
	} port_addr_u;

endpackage

/* zports_tb.sv */
// zports_tb: table-driven testbench for the z80 i/o port block with a uart responder
`timescale 1ns/100ps

module zports_tb;

	localparam int K_RD  = 0;
	localparam int K_WR  = 1;
	localparam int K_CHK = 2; // check only, no bus cycle

	logic        zclk;
	logic        rst;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq;
	logic        rd;
	logic        wr;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [4:0]  kj_in;
	logic [7:0]  sd_dataout;
	logic        com_ack;
	logic [7:0]  com_rdata;
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic [31:0] xt_page;
	logic [7:0]  sysconf;
	logic [7:0]  memconf;
	logic [7:0]  im2vect;
	logic        sdcs_n;
	logic        sd_start;
	logic [7:0]  sd_datain;
	logic        com_req;
	logic        com_rnw;
	logic [2:0]  com_unit;
	logic [7:0]  com_wdata;
	logic        io_wait;

	// stimulus table, one entry per row in each queue
	int          row_kind[$];
	logic [15:0] row_addr[$];
	logic [7:0]  row_data[$];
	logic        row_dos[$];
	string       row_sig[$];
	logic [31:0] row_exp[$];

	logic [7:0]  rd_data;   // dout in the last cycle of a read
	logic        rd_hit;
	logic [7:0]  sd_din_seen; // sd_datain in the last cycle of an access
	logic        wait_seen;   // io_wait high at some point in the access
	logic [2:0]  hs_unit;   // what the responder saw at ack
	logic [7:0]  hs_wdata;
	logic        hs_rnw;
	int          sd_count;
	int          sd_seen;   // sd_start pulses during the last access
	int          cycle_cnt;
	int          limit;
	int          fail_cnt;
	int          pass_cnt;

	zports DUT (.*);

	always #10 zclk = ~zclk;

	always @(negedge zclk)
	begin
		if (sd_start)
			sd_count++;
	end

	always @(posedge zclk)
	begin
		cycle_cnt++;
		if (limit > 0 && cycle_cnt > limit)
		begin
			$display("run stopped after %0d cycles, a bus access never completed", cycle_cnt);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic add_row(input int kind, input logic [15:0] addr, input logic [7:0] data,
		input logic dos_val, input string sig, input logic [31:0] exp);
		row_kind.push_back(kind);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_dos.push_back(dos_val);
		row_sig.push_back(sig);
		row_exp.push_back(exp);
	endtask

	// internal port map, 7ffd needs a15 low, 1f and the sd ports count outside dos
	function automatic logic expected_porthit(input logic [15:0] addr, input logic dos_val);
		case (addr[7:0])
			8'hFE, 8'hAF, 8'hEF: expected_porthit = 1'b1;
			8'hFD:               expected_porthit = ~addr[15];
			8'h1F, 8'h77, 8'h57: expected_porthit = ~dos_val;
			default:             expected_porthit = 1'b0;
		endcase
	endfunction

	// z80 i/o cycle, at least four clocks and held while io_wait is high
	task automatic bus_access(input int kind, input logic [15:0] addr, input logic [7:0] data,
		input logic dos_val);
		int   cycles;
		int   base;
		logic exp_hit;
		logic exp_out;
		cycles = 0;
		base = sd_count;
		wait_seen = 1'b0;
		exp_hit = expected_porthit(addr, dos_val);
		exp_out = exp_hit & (kind == K_RD);
		a = addr;
		din = data;
		dos = dos_val;
		iorq = 1'b1;
		rd = (kind == K_RD);
		wr = (kind == K_WR);
		while (cycles < 4 || io_wait)
		begin
			@(posedge zclk);
			#1;
			cycles++;
			if (io_wait)
				wait_seen = 1'b1;
		end
		rd_data = dout;
		rd_hit = porthit;
		sd_din_seen = sd_datain;
		assert (porthit === exp_hit)
		else
			$display("error: porthit is %h, expected %h at port %h", porthit, exp_hit, addr);
		assert (dataout === exp_out)
		else
			$display("error: dataout is %h, expected %h at port %h", dataout, exp_out, addr);
		if (porthit !== exp_hit || dataout !== exp_out)
			fail_cnt++;
		#1;
		iorq = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		dos = 1'b0;
		@(posedge zclk); // idle cycle between accesses
		#2;
		sd_seen = sd_count - base;
	endtask

	function automatic logic [31:0] observed(input string name);
		case (name)
			"dout":      observed = {24'h0, rd_data};
			"porthit":   observed = {31'h0, rd_hit};
			"sysconf":   observed = {24'h0, sysconf};
			"memconf":   observed = {24'h0, memconf};
			"im2vect":   observed = {24'h0, im2vect};
			"xt_page":   observed = xt_page;
			"sdcs_n":    observed = {31'h0, sdcs_n};
			"sd_pulses": observed = sd_seen;
			"sd_datain": observed = {24'h0, sd_din_seen};
			"com_unit":  observed = {29'h0, hs_unit};
			"com_wdata": observed = {24'h0, hs_wdata};
			"com_rnw":   observed = {31'h0, hs_rnw};
			"io_wait":   observed = {31'h0, wait_seen}; // cpu stalled in the last access
			default:     observed = 32'hFFFF_FFFF;
		endcase
	endfunction

	// uart model, answers each request after 1..6 cycles
	initial
	begin
		int delay;
		void'($urandom(32'hc8));
		com_ack = 1'b0;
		com_rdata = 8'h00;
		forever
		begin
			@(posedge zclk);
			#1;
			if (com_req && !com_ack)
			begin
				delay = 1 + ($urandom % 6);
				repeat (delay) @(posedge zclk);
				#2;
				hs_unit = com_unit;
				hs_wdata = com_wdata;
				hs_rnw = com_rnw;
				com_rdata = com_rnw ? ({5'b0, com_unit} ^ 8'hA5) : 8'h00;
				com_ack = 1'b1;
				while (com_req)
				begin
					@(posedge zclk);
					#1;
				end
				#1;
				com_ack = 1'b0;
			end
		end
	end

	initial
	begin
		logic [31:0] got;
		logic        ok;
		zclk = 1'b0;
		rst = 1'b1;
		a = 16'h0000;
		din = 8'h00;
		iorq = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		dos = 1'b0;
		keys_in = 5'h15;
		tape_read = 1'b1;
		kj_in = 5'h0A;
		sd_dataout = 8'h3C;

		// reset values and the power-up flag
		add_row(K_RD, 16'h10AF, 8'h00, 1'b0, "dout", 32'h00);
		add_row(K_RD, 16'h11AF, 8'h00, 1'b0, "dout", 32'h05);
		add_row(K_RD, 16'h12AF, 8'h00, 1'b0, "dout", 32'h02);
		add_row(K_RD, 16'h13AF, 8'h00, 1'b0, "dout", 32'h00);
		add_row(K_RD, 16'h20AF, 8'h00, 1'b0, "dout", 32'h01);
		add_row(K_RD, 16'h21AF, 8'h00, 1'b0, "dout", 32'h04);
		add_row(K_RD, 16'h25AF, 8'h00, 1'b0, "dout", 32'hFF);
		add_row(K_CHK, 16'h0000, 8'h00, 1'b0, "xt_page", 32'h0002_0500);
		add_row(K_RD, 16'h00AF, 8'h00, 1'b0, "dout", 32'h20);
		add_row(K_RD, 16'h00AF, 8'h00, 1'b0, "dout", 32'h00);
		// extended register writes
		add_row(K_WR, 16'h20AF, 8'h5A, 1'b0, "sysconf", 32'h5A);
		add_row(K_WR, 16'h21AF, 8'h33, 1'b0, "memconf", 32'h33);
		add_row(K_WR, 16'h25AF, 8'hC7, 1'b0, "im2vect", 32'hC7);
		add_row(K_WR, 16'h12AF, 8'h1E, 1'b0, "xt_page", 32'h001E_0500);
		add_row(K_RD, 16'h25AF, 8'h00, 1'b0, "dout", 32'hC7);
		add_row(K_WR, 16'h30AF, 8'h99, 1'b0, "sysconf", 32'h5A); // unused index
		// 7ffd paging, 128k lock mode, self-lock
		add_row(K_WR, 16'h7FFD, 8'hC6, 1'b0, "xt_page", 32'h1E1E_0500);
		add_row(K_WR, 16'h21AF, 8'h40, 1'b0, "memconf", 32'h40);
		add_row(K_WR, 16'h7FFD, 8'hD5, 1'b0, "xt_page", 32'h051E_0500);
		add_row(K_WR, 16'hFFFD, 8'h07, 1'b0, "memconf", 32'h41);
		add_row(K_WR, 16'h21AF, 8'h00, 1'b0, "memconf", 32'h00);
		add_row(K_WR, 16'h7FFD, 8'h62, 1'b0, "xt_page", 32'h0A1E_0500);
		add_row(K_WR, 16'h7FFD, 8'h17, 1'b0, "memconf", 32'h00);
		add_row(K_CHK, 16'h0000, 8'h00, 1'b0, "xt_page", 32'h0A1E_0500);
		// read-only ports
		add_row(K_RD, 16'h7FFE, 8'h00, 1'b0, "dout", 32'hD5);
		add_row(K_RD, 16'h001F, 8'h00, 1'b0, "dout", 32'h0A);
		add_row(K_RD, 16'h001F, 8'h00, 1'b1, "dout", 32'hFF);
		add_row(K_RD, 16'h00FB, 8'h00, 1'b0, "porthit", 32'h0);
		add_row(K_RD, 16'h00FB, 8'h00, 1'b0, "dout", 32'hFF);
		// sd card
		add_row(K_WR, 16'h0077, 8'h00, 1'b0, "sdcs_n", 32'h0);
		add_row(K_WR, 16'h0077, 8'h02, 1'b1, "sdcs_n", 32'h0);
		add_row(K_WR, 16'h0077, 8'h02, 1'b0, "sdcs_n", 32'h1);
		add_row(K_WR, 16'h0057, 8'h81, 1'b0, "sd_pulses", 32'h1);
		add_row(K_CHK, 16'h0000, 8'h00, 1'b0, "sd_datain", 32'h81);
		add_row(K_RD, 16'h0057, 8'h00, 1'b0, "sd_pulses", 32'h1);
		add_row(K_RD, 16'h0057, 8'h00, 1'b0, "dout", 32'h3C);
		add_row(K_CHK, 16'h0000, 8'h00, 1'b0, "sd_datain", 32'hFF);
		// uart bridge
		add_row(K_WR, 16'hFDEF, 8'h6B, 1'b0, "com_wdata", 32'h6B);
		add_row(K_CHK, 16'h0000, 8'h00, 1'b0, "com_unit", 32'h5);
		add_row(K_CHK, 16'h0000, 8'h00, 1'b0, "com_rnw", 32'h0);
		add_row(K_RD, 16'hFBEF, 8'h00, 1'b0, "dout", 32'hA6);
		add_row(K_CHK, 16'h0000, 8'h00, 1'b0, "com_rnw", 32'h1);
		add_row(K_RD, 16'hFFEF, 8'h00, 1'b0, "dout", 32'hA2);
		add_row(K_CHK, 16'h0000, 8'h00, 1'b0, "io_wait", 32'h1);
		limit = 40 * row_kind.size() + 200;

		repeat (8) @(posedge zclk);
		#2;
		rst = 1'b0;
		@(posedge zclk);
		#2;

		for (int i = 0; i < row_kind.size(); i++)
		begin
			if (row_kind[i] != K_CHK)
				bus_access(row_kind[i], row_addr[i], row_data[i], row_dos[i]);
			got = observed(row_sig[i]);
			ok = (got === row_exp[i]);
			assert (ok)
			else
				$display("error: %s is %h, expected %h", row_sig[i], got, row_exp[i]);
			if (ok)
				pass_cnt++;
			else
				fail_cnt++;
			$display("test %0d port %h %s %s", i, row_addr[i], row_sig[i], ok ? "ok" : "mismatch");
		end

		fail_cnt = fail_cnt + DUT.u_assert.fail_cnt; // protocol violations
		$display("tests passed %0d, failures %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
